// File: Makefile
# Verilator build and run for the ARM core testbench

VERILATOR ?= verilator
TOP       ?= armCoreTb
FILELIST  ?= armCore.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: armCore.f
+incdir+common
common/armPkg.sv
control/instrDecoder.sv
control/condUnit.sv
datapath/regFile.sv
datapath/alu.sv
datapath/datapath.sv
logic/armCore.sv
tb/armCoreTb.sv

// File: common/armCore_settings.svh
// Core-wide widths, PC constants and instruction field positions, included by RTL files
`ifndef ARMCORE_SETTINGS_SVH
`define ARMCORE_SETTINGS_SVH

// Data and address width
`define ARM_WORD_W 32

// Stored general registers, R15 is not one of them
`define ARM_REG_COUNT 15

`define ARM_PC_STEP 4
`define ARM_RESET_PC 0

// Index that reads back as PC+8
`define ARM_PC_REG 15

// Low bit of each instruction field
`define ARM_COND_LSB 28
`define ARM_OP_LSB 26
`define ARM_FUNCT_LSB 20
`define ARM_RN_LSB 16
`define ARM_RD_LSB 12
`define ARM_RM_LSB 0

`endif

// File: common/armPkg.sv
// Shared types for the ARM core, imported by every RTL module
`include "armCore_settings.svh"

package armPkg;

   typedef logic [`ARM_WORD_W-1:0] wordT;
   typedef logic [3:0] regIdxT;

   // Instruction class, bits 27:26
   typedef enum logic [1:0] {
      OP_DP  = 2'b00,
      OP_MEM = 2'b01,
      OP_BR  = 2'b10
   } opT;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_ORR,
      ALU_EOR
   } aluOpT;

   typedef enum logic [1:0] {
      IMM_8,    // Data processing immediate
      IMM_12,   // Load/store offset
      IMM_BR24  // Branch offset, word scaled
   } immSrcT;

   // Encodings follow the cond field directly
   typedef enum logic [3:0] {
      COND_EQ, COND_NE, COND_CS, COND_CC,
      COND_MI, COND_PL, COND_VS, COND_VC,
      COND_HI, COND_LS, COND_GE, COND_LT,
      COND_GT, COND_LE, COND_AL
   } condT;

   typedef struct packed {
      logic neg;
      logic zero;
      logic carry;
      logic overflow;
   } flagsT;

endpackage

// File: control/condUnit.sv
// Flags register and condition check that gate the register, memory and PC writes
module condUnit import armPkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       fetchReady,
   input  condT       cond,
   input  flagsT      aluFlags,
   input  logic       regWriteRaw,
   input  logic       memWriteRaw,
   input  logic [1:0] flagWriteRaw,
   input  logic       branch,
   output logic       regWrite,
   output logic       memWrite,
   output logic       pcBranch
);

   logic [1:0] nzFlags;
   logic [1:0] cvFlags;
   flagsT      flags;
   logic       condEx;
   logic       commit;
   logic [1:0] flagWrite;
   logic       ge;

   // Upper half N and Z, lower half C and V
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         nzFlags <= 2'b00;
      end else if (flagWrite[1]) begin
         nzFlags <= {aluFlags.neg, aluFlags.zero};
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         cvFlags <= 2'b00;
      end else if (flagWrite[0]) begin
         cvFlags <= {aluFlags.carry, aluFlags.overflow};
      end
   end

   assign flags = {nzFlags, cvFlags};
   assign ge    = (flags.neg == flags.overflow);

   always_comb begin
      case (cond)
         COND_EQ: condEx = flags.zero;
         COND_NE: condEx = ~flags.zero;
         COND_CS: condEx = flags.carry;
         COND_CC: condEx = ~flags.carry;
         COND_MI: condEx = flags.neg;
         COND_PL: condEx = ~flags.neg;
         COND_VS: condEx = flags.overflow;
         COND_VC: condEx = ~flags.overflow;
         COND_HI: condEx = flags.carry & ~flags.zero;
         COND_LS: condEx = ~flags.carry | flags.zero;
         COND_GE: condEx = ge;
         COND_LT: condEx = ~ge;
         COND_GT: condEx = ge & ~flags.zero;
         COND_LE: condEx = ~ge | flags.zero;
         COND_AL: condEx = 1'b1;
         default: condEx = 1'b0;  // 4'b1111 never executes
      endcase
   end

   assign commit    = condEx & fetchReady & ~reset;  // Nothing changes in a stall or in reset
   assign flagWrite = flagWriteRaw & {2{commit}};
   assign regWrite  = regWriteRaw & commit;
   assign memWrite  = memWriteRaw & commit;
   assign pcBranch  = branch & commit;

   flagsHoldOnStall: assert property (@(posedge clk) disable iff (reset)
      !fetchReady |=> $stable(flags))
      else $error("Flags changed across a stalled cycle");

endmodule

// File: control/instrDecoder.sv
// Combinational decoder turning opcode and function bits into datapath and write controls
`include "armCore_settings.svh"

module instrDecoder import armPkg::*; (
   input  wordT       instr,
   output aluOpT      aluOp,
   output immSrcT     immSrc,
   output logic       aluSrcImm,
   output logic       memToReg,
   output logic       regSrcStore,
   output logic       branch,
   output logic       regWriteRaw,
   output logic       memWriteRaw,
   output logic [1:0] flagWriteRaw
);

   // Data processing command field in bits 24:21
   localparam logic [3:0] CMD_AND = 4'b0000;
   localparam logic [3:0] CMD_EOR = 4'b0001;
   localparam logic [3:0] CMD_SUB = 4'b0010;
   localparam logic [3:0] CMD_ADD = 4'b0100;
   localparam logic [3:0] CMD_CMP = 4'b1010;
   localparam logic [3:0] CMD_ORR = 4'b1100;

   opT         op;
   logic [5:0] funct;
   logic       sBit;
   logic       cmdKnown;

   assign op    = opT'(instr[`ARM_OP_LSB +: 2]);
   assign funct = instr[`ARM_FUNCT_LSB +: 6];
   assign sBit  = funct[0];  // L bit for loads and stores

   always_comb begin
      aluOp        = ALU_ADD;
      immSrc       = IMM_8;
      aluSrcImm    = 1'b0;
      memToReg     = 1'b0;
      regSrcStore  = 1'b0;
      branch       = 1'b0;
      regWriteRaw  = 1'b0;
      memWriteRaw  = 1'b0;
      flagWriteRaw = 2'b00;
      cmdKnown     = 1'b1;
      case (op)
         OP_DP: begin
            aluSrcImm   = funct[5];
            regWriteRaw = 1'b1;
            case (funct[4:1])
               CMD_ADD: aluOp = ALU_ADD;
               CMD_SUB: aluOp = ALU_SUB;
               CMD_AND: aluOp = ALU_AND;
               CMD_ORR: aluOp = ALU_ORR;
               CMD_EOR: aluOp = ALU_EOR;
               CMD_CMP: begin
                  aluOp       = ALU_SUB;
                  regWriteRaw = 1'b0;  // Flags only
               end
               default: begin
                  // Unsupported command runs as a no-op
                  cmdKnown    = 1'b0;
                  regWriteRaw = 1'b0;
               end
            endcase
            if (cmdKnown) begin
               flagWriteRaw[1] = sBit;  // N and Z
               flagWriteRaw[0] = sBit && (aluOp == ALU_ADD || aluOp == ALU_SUB);
            end
         end
         OP_MEM: begin
            aluSrcImm   = 1'b1;
            immSrc      = IMM_12;
            memToReg    = sBit;
            regWriteRaw = sBit;
            memWriteRaw = ~sBit;
            regSrcStore = ~sBit;  // Store data comes from rd
         end
         OP_BR: begin
            aluSrcImm = 1'b1;
            immSrc    = IMM_BR24;
            branch    = 1'b1;
         end
         default: ;
      endcase
   end

   always_comb begin
      if (!$isunknown(op) && (op inside {OP_DP, OP_MEM, OP_BR})) begin
         assert (!$isunknown({aluOp, immSrc, aluSrcImm, memToReg, regSrcStore,
                              branch, regWriteRaw, memWriteRaw, flagWriteRaw}))
            else $error("Decoder drove unknown controls for a supported class");
      end
   end

endmodule

// File: datapath/alu.sv
// Combinational ALU for add, subtract and logic operations with N, Z, C and V flags
`include "armCore_settings.svh"

module alu import armPkg::*; (
   input  wordT  a,
   input  wordT  b,
   input  aluOpT aluOp,
   output wordT  result,
   output flagsT flags
);

   localparam int MSB = `ARM_WORD_W - 1;

   logic                 isSub;
   logic                 isArith;
   wordT                 bAdj;
   logic [`ARM_WORD_W:0] sum;

   assign isSub   = (aluOp == ALU_SUB);
   assign isArith = (aluOp == ALU_ADD) || isSub;

   // Subtract as a + ~b + 1
   assign bAdj = isSub ? ~b : b;
   assign sum  = {1'b0, a} + {1'b0, bAdj} + {{`ARM_WORD_W{1'b0}}, isSub};

   always_comb begin
      case (aluOp)
         ALU_ADD,
         ALU_SUB: result = sum[MSB:0];
         ALU_AND: result = a & b;
         ALU_ORR: result = a | b;
         ALU_EOR: result = a ^ b;
         default: result = '0;
      endcase
   end

   assign flags.neg  = result[MSB];
   assign flags.zero = (result == '0);

   // Carry out of the adder, subtract gives not-borrow
   assign flags.carry = isArith & sum[`ARM_WORD_W];

   // Operands agree in sign but the sum does not
   assign flags.overflow = isArith & (a[MSB] == bAdj[MSB]) & (sum[MSB] != a[MSB]);

endmodule

// File: datapath/datapath.sv
// PC register, register file, immediate extension, ALU and result selection of the core
`include "armCore_settings.svh"

module datapath import armPkg::*; (
   input  logic   clk,
   input  logic   reset,
   input  logic   fetchReady,
   input  wordT   instr,
   input  aluOpT  aluOp,
   input  immSrcT immSrc,
   input  logic   aluSrcImm,
   input  logic   memToReg,
   input  logic   regSrcStore,
   input  logic   regWrite,
   input  logic   pcBranch,
   input  wordT   readData,
   output wordT   pc,
   output flagsT  aluFlags,
   output wordT   dataAddr,
   output wordT   writeData
);

   wordT   pcNext;
   wordT   pcPlus4;
   wordT   pcPlus8;
   wordT   extImm;
   wordT   srcA;
   wordT   srcB;
   wordT   regB;
   wordT   aluResult;
   wordT   result;
   regIdxT rn;
   regIdxT rd;
   regIdxT rm;
   regIdxT readAddrA;
   regIdxT readAddrB;

   assign rn = instr[`ARM_RN_LSB +: 4];
   assign rd = instr[`ARM_RD_LSB +: 4];
   assign rm = instr[`ARM_RM_LSB +: 4];

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         pc <= wordT'(`ARM_RESET_PC);
      end else if (fetchReady) begin
         pc <= pcNext;
      end
   end

   assign pcPlus4 = pc + `ARM_PC_STEP;
   assign pcPlus8 = pcPlus4 + `ARM_PC_STEP;
   assign pcNext  = pcBranch ? aluResult : pcPlus4;  // Target is PC+8 plus offset

   // Branch bases its target on R15, a failed branch discards the sum
   assign readAddrA = pcBranch ? regIdxT'(`ARM_PC_REG) : rn;
   assign readAddrB = regSrcStore ? rd : rm;

   regFile regs (
      .clk       (clk),
      .writeEn   (regWrite),
      .readAddrA (readAddrA),
      .readAddrB (readAddrB),
      .writeAddr (rd),
      .writeValue(result),
      .pcPlus8   (pcPlus8),
      .readA     (srcA),
      .readB     (regB)
   );

   always_comb begin
      case (immSrc)
         IMM_8:    extImm = wordT'(instr[7:0]);
         IMM_12:   extImm = wordT'(instr[11:0]);
         IMM_BR24: extImm = {{6{instr[23]}}, instr[23:0], 2'b00};
         default:  extImm = '0;
      endcase
   end

   assign srcB = aluSrcImm ? extImm : regB;

   alu aluUnit (
      .a     (srcA),
      .b     (srcB),
      .aluOp (aluOp),
      .result(aluResult),
      .flags (aluFlags)
   );

   assign result    = memToReg ? readData : aluResult;
   assign dataAddr  = aluResult;
   assign writeData = regB;

   pcWordAligned: assert property (@(posedge clk) disable iff (reset)
      pc[1:0] == 2'b00)
      else $error("PC left word alignment");

endmodule

// File: datapath/regFile.sv
// Register file with two combinational read ports and one clocked write port, R15 as PC+8
`include "armCore_settings.svh"

module regFile import armPkg::*; (
   input  logic   clk,
   input  logic   writeEn,
   input  regIdxT readAddrA,
   input  regIdxT readAddrB,
   input  regIdxT writeAddr,
   input  wordT   writeValue,
   input  wordT   pcPlus8,
   output wordT   readA,
   output wordT   readB
);

   wordT regs [`ARM_REG_COUNT];

   always_ff @(posedge clk) begin
      if (writeEn) begin
         regs[writeAddr] <= writeValue;
      end
   end

   // R15 is not stored
   assign readA = (readAddrA == regIdxT'(`ARM_PC_REG)) ? pcPlus8 : regs[readAddrA];
   assign readB = (readAddrB == regIdxT'(`ARM_PC_REG)) ? pcPlus8 : regs[readAddrB];

   // Decoded writes to R15 are unsupported and must never reach here
   noPcRegWrite: assert property (@(posedge clk)
      writeEn |-> (writeAddr != regIdxT'(`ARM_PC_REG)))
      else $error("Register write aimed at R15");

endmodule

// File: logic/armCore.sv
// Top of the single-cycle ARM core, joining decoder, condition unit and datapath
`include "armCore_settings.svh"

module armCore import armPkg::*; (
   input  logic clk,
   input  logic reset,
   input  logic fetchReady,
   output wordT pc,
   input  wordT instr,
   output logic memWrite,
   output wordT dataAddr,
   output wordT writeData,
   input  wordT readData
);

   aluOpT      aluOp;
   immSrcT     immSrc;
   logic       aluSrcImm;
   logic       memToReg;
   logic       regSrcStore;
   logic       branch;
   logic       regWriteRaw;
   logic       memWriteRaw;
   logic [1:0] flagWriteRaw;
   logic       regWrite;
   logic       pcBranch;
   flagsT      aluFlags;

   instrDecoder decoder (
      .instr       (instr),
      .aluOp       (aluOp),
      .immSrc      (immSrc),
      .aluSrcImm   (aluSrcImm),
      .memToReg    (memToReg),
      .regSrcStore (regSrcStore),
      .branch      (branch),
      .regWriteRaw (regWriteRaw),
      .memWriteRaw (memWriteRaw),
      .flagWriteRaw(flagWriteRaw)
   );

   condUnit condCtrl (
      .clk         (clk),
      .reset       (reset),
      .fetchReady  (fetchReady),
      .cond        (condT'(instr[`ARM_COND_LSB +: 4])),
      .aluFlags    (aluFlags),
      .regWriteRaw (regWriteRaw),
      .memWriteRaw (memWriteRaw),
      .flagWriteRaw(flagWriteRaw),
      .branch      (branch),
      .regWrite    (regWrite),
      .memWrite    (memWrite),
      .pcBranch    (pcBranch)
   );

   datapath dp (
      .clk        (clk),
      .reset      (reset),
      .fetchReady (fetchReady),
      .instr      (instr),
      .aluOp      (aluOp),
      .immSrc     (immSrc),
      .aluSrcImm  (aluSrcImm),
      .memToReg   (memToReg),
      .regSrcStore(regSrcStore),
      .regWrite   (regWrite),
      .pcBranch   (pcBranch),
      .readData   (readData),
      .pc         (pc),
      .aluFlags   (aluFlags),
      .dataAddr   (dataAddr),  // ALU result addresses data memory
      .writeData  (writeData)
   );

endmodule

// File: tb/armCoreTb.sv
// Simulation top for the ARM core with memories, random fetch stalls and pc and store checks
module armCoreTb import armPkg::*; ();

   localparam int NUM_INSTRS  = 30;                   // Executed instructions incl. branch
   localparam int MAX_CYCLES  = NUM_INSTRS * 12 + 40; // Room for long stall runs
   localparam int NUM_STORES  = 11;
   localparam int NUM_SKIPPED = 5;
   localparam wordT END_PC        = 32'h7C;
   localparam wordT LOAD_ADDR     = 32'h6C;  // Stored and then loaded back
   localparam wordT LOAD_PLUS_ONE = 32'h70;

   logic clk;
   logic reset;
   logic fetchReady;
   logic memWrite;
   wordT pc;
   wordT instr;
   wordT dataAddr;
   wordT writeData;
   wordT readData;
   wordT expPc;
   wordT instrMem [64];
   wordT dataMem [64];
   int   errorCount = 0;
   int   storeCount = 0;
   int   cycleCount = 0;

   // Expected stores in program order as worked out by hand
   wordT  expAddr [NUM_STORES] = '{32'h40, 32'h44, 32'h48, 32'h4C, 32'h50, 32'h58,
                                  32'h5C, 32'h64, 32'h6C, 32'h70, 32'h7C};
   wordT  expData [NUM_STORES] = '{32'h12, 32'h48, 32'hDE, 32'h96, 32'h40, 32'h12,
                                  32'hDE, 32'h5A, 32'h48, 32'h49, 32'h19};
   string storeName [NUM_STORES] = '{"ADD/SUB immediate", "AND register", "ORR register",
                                     "EOR register", "VS after ADDS", "HI after ADDS",
                                     "EQ after CMP", "CS after CMP", "STR before LDR",
                                     "LDR plus one", "after branch"};

   // Failed VC, failed NE, failed HI, then the two stores jumped over
   wordT skipAddr [NUM_SKIPPED] = '{32'h54, 32'h60, 32'h68, 32'h74, 32'h78};

   armCore dut (
      .clk       (clk),
      .reset     (reset),
      .fetchReady(fetchReady),
      .pc        (pc),
      .instr     (instr),
      .memWrite  (memWrite),
      .dataAddr  (dataAddr),
      .writeData (writeData),
      .readData  (readData)
   );

   assign instr    = instrMem[pc[7:2]];
   assign readData = dataMem[dataAddr[7:2]];

   always @(posedge clk) begin
      if (memWrite) begin
         dataMem[dataAddr[7:2]] <= writeData;
      end
   end

   task automatic reportMismatch(input string testName, input wordT expected, input wordT actual);
      errorCount++;
      $display("Error: %s expected %h actual %h", testName, expected, actual);
   endtask

   task automatic reportProblem(input string text);
      errorCount++;
      $display("Error: %s", text);
   endtask

   // Branch targets of the program
   function automatic wordT nextPcOf(input wordT pcVal);
      case (pcVal)
         32'h6C:  return 32'h78;
         32'h7C:  return 32'h7C;
         default: return pcVal + 32'd4;
      endcase
   endfunction

   function automatic logic isSkipped(input wordT addr);
      logic hit;
      hit = 1'b0;
      for (int k = 0; k < NUM_SKIPPED; k++) begin
         if (addr == skipAddr[k]) hit = 1'b1;
      end
      return hit;
   endfunction

   // Value the store table puts at an address
   function automatic wordT storedAt(input wordT addr);
      wordT value;
      value = '0;
      for (int k = 0; k < NUM_STORES; k++) begin
         if (expAddr[k] == addr) begin
            value = expData[k];
         end
      end
      return value;
   endfunction

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Reset and then fetchReady low on about one cycle in four
   initial begin
      void'($urandom(32'h1f7b4da6));
      reset      = 1'b1;
      fetchReady = 1'b0;
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      forever begin
         fetchReady <= ($urandom % 4) != 0;
         @(posedge clk);
      end
   end

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
   end

   // Pc follows the program and holds while stalled
   always @(posedge clk) begin
      if (reset) begin
         resetPc: assert (pc == 32'h0) else reportMismatch("reset pc", 32'h0, pc);
         expPc <= 32'h0;
      end else begin
         pcOrder: assert (pc == expPc) else reportMismatch("pc sequence", expPc, pc);
         expPc <= fetchReady ? nextPcOf(pc) : pc;
      end
   end

   always @(posedge clk) begin
      if (!reset && memWrite) begin
         storeInList: assert (storeCount < NUM_STORES)
            else reportProblem($sformatf("store to %h of %h beyond the expected list",
                                         dataAddr, writeData));
         if (storeCount < NUM_STORES) begin
            storeAddr: assert (dataAddr == expAddr[storeCount])
               else reportMismatch({storeName[storeCount], " address"},
                                   expAddr[storeCount], dataAddr);
            storeValue: assert (writeData == expData[storeCount])
               else reportMismatch({storeName[storeCount], " value"},
                                   expData[storeCount], writeData);
         end
         skippedStore: assert (!isSkipped(dataAddr))
            else reportProblem($sformatf("store to %h, which the program never reaches",
                                         dataAddr));
         if (dataAddr == LOAD_PLUS_ONE) begin
            loadPath: assert (writeData == storedAt(LOAD_ADDR) + 32'd1)
               else reportMismatch("load path", storedAt(LOAD_ADDR) + 32'd1, writeData);
         end
         storeCount <= storeCount + 1;
      end
   end

   stallStoreLow: assert property (@(posedge clk) disable iff (reset) !fetchReady |-> !memWrite)
      else reportProblem("memWrite was high while fetchReady was low");

   stallPcHold: assert property (@(posedge clk) disable iff (reset) !fetchReady |=> $stable(pc))
      else reportProblem("pc changed across a stalled cycle");

   initial begin
      $readmemh("tb/program.hex", instrMem);
      // Top bit set so the word loaded from 0x20 overflows when doubled
      for (int i = 0; i < 64; i++) begin
         dataMem[i] <= 32'h8000_0000 | (i * 4);
      end
      while (!(pc == END_PC && storeCount == NUM_STORES) && cycleCount < MAX_CYCLES) begin
         @(posedge clk);
      end
      repeat (4) @(posedge clk);  // Spin on the branch-to-self
      if (cycleCount >= MAX_CYCLES) begin
         reportProblem($sformatf("run hit the %0d cycle limit at pc %h with %0d of %0d stores",
                                 MAX_CYCLES, pc, storeCount, NUM_STORES));
      end
      $display("Stores seen %0d of %0d, cycles %0d, errors %0d",
               storeCount, NUM_STORES, cycleCount, errorCount);
      if (errorCount == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: tb/program.hex
// Instruction memory image, one 32-bit word per line starting at address 0x00
// Each line is followed by its address and assembly
E04F000F // 00 SUB   R0, R15, R15
E2801040 // 04 ADD   R1, R0, #0x40
E2802019 // 08 ADD   R2, R0, #25
E2423007 // 0C SUB   R3, R2, #7
E5813000 // 10 STR   R3, [R1, #0]
E28040CC // 14 ADD   R4, R0, #0xCC
E280505A // 18 ADD   R5, R0, #0x5A
E0046005 // 1C AND   R6, R4, R5
E1847005 // 20 ORR   R7, R4, R5
E0248005 // 24 EOR   R8, R4, R5
E5816004 // 28 STR   R6, [R1, #4]
E5817008 // 2C STR   R7, [R1, #8]
E581800C // 30 STR   R8, [R1, #12]
E5909020 // 34 LDR   R9, [R0, #0x20]
E099A009 // 38 ADDS  R10, R9, R9
6581A010 // 3C STRVS R10, [R1, #16]
75812014 // 40 STRVC R2, [R1, #20]
85813018 // 44 STRHI R3, [R1, #24]
E3520019 // 48 CMP   R2, #25
0581701C // 4C STREQ R7, [R1, #28]
15818020 // 50 STRNE R8, [R1, #32]
25815024 // 54 STRCS R5, [R1, #36]
85814028 // 58 STRHI R4, [R1, #40]
E581602C // 5C STR   R6, [R1, #44]
E591B02C // 60 LDR   R11, [R1, #44]
E28BC001 // 64 ADD   R12, R11, #1
E581C030 // 68 STR   R12, [R1, #48]
EA000001 // 6C B     0x78
E5812034 // 70 STR   R2, [R1, #52]
E5813038 // 74 STR   R3, [R1, #56]
E581203C // 78 STR   R2, [R1, #60]
EAFFFFFE // 7C B     0x7C
